//--- common/tcp_ip_pkg.sv
package tcp_ip_pkg;

    // transmit streams sharing the ip header output
    localparam int NUM_TCP = 8;

    // must cover NUM_TCP
    localparam int STREAM_IDX_W = 3;

    // ipv4 addresses
    typedef logic [31:0] ip_addr_t;

    // time to live
    typedef logic [7:0] ttl_t;

    // protocol number, 6 for tcp
    typedef logic [7:0] proto_t;

    // differentiated services code point
    typedef logic [5:0] dscp_t;

    // explicit congestion notification
    typedef logic [1:0] ecn_t;

    // total ip length in bytes
    typedef logic [15:0] ip_len_t;

endpackage

//--- common/tcp_regs_pkg.sv
package tcp_regs_pkg;

    // cpu register port
    localparam int CPU_ADDR_W = 5;
    localparam int CPU_DATA_W = 32;

    // word address split into {stream, register}
    localparam int REG_SEL_W = 2;
    localparam int STREAM_LSB = REG_SEL_W;

    typedef enum logic [REG_SEL_W-1:0] {
        REG_CTRL   = 2'd0,
        REG_SRC_IP = 2'd1,
        REG_DST_IP = 2'd2,
        REG_HDR    = 2'd3
    } reg_sel_e;

    // ctrl register
    localparam int CTRL_SEND_BIT = 0;
    localparam int CTRL_LEN_LSB = 16;

    // hdr register
    localparam int HDR_TTL_LSB = 0;
    localparam int HDR_PROTO_LSB = 8;
    localparam int HDR_DSCP_LSB = 16;
    localparam int HDR_ECN_LSB = 22;

endpackage

//--- rtl/tcp_reg_decode.sv
`timescale 1ns/1ps

module tcp_reg_decode (
    input  logic                                    i_clk,
    input  logic                                    i_rst,

    input  logic                                    i_cpu_req,
    input  logic                                    i_cpu_req_is_wr,
    input  logic [tcp_regs_pkg::CPU_ADDR_W-1:0]     i_cpu_addr,

    output logic [tcp_ip_pkg::NUM_TCP-1:0]          o_wr_en,
    output tcp_regs_pkg::reg_sel_e                  o_reg_sel,
    input  logic [tcp_ip_pkg::NUM_TCP-1:0][tcp_regs_pkg::CPU_DATA_W-1:0] i_rd_words,

    output logic                                    o_cpu_rd_ack,
    output logic                                    o_cpu_wr_ack,
    output logic [tcp_regs_pkg::CPU_DATA_W-1:0]     o_cpu_rd_data
);

logic [tcp_ip_pkg::STREAM_IDX_W-1:0] stream_idx;
logic                                wr_req;
logic                                rd_req;

// address split
assign stream_idx = i_cpu_addr[tcp_regs_pkg::STREAM_LSB +: tcp_ip_pkg::STREAM_IDX_W];
assign o_reg_sel  = tcp_regs_pkg::reg_sel_e'(i_cpu_addr[0 +: tcp_regs_pkg::REG_SEL_W]);

assign wr_req = i_cpu_req && i_cpu_req_is_wr;
assign rd_req = i_cpu_req && !i_cpu_req_is_wr;

// one-hot write strobe to the addressed stream
always_comb begin
    o_wr_en = '0;
    if (wr_req) begin
        o_wr_en[stream_idx] = 1'b1;
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_cpu_rd_ack <= 1'b0;
        o_cpu_wr_ack <= 1'b0;
    end else begin
        o_cpu_rd_ack <= rd_req;
        o_cpu_wr_ack <= wr_req;
    end
end

// read word captured with the request, valid alongside rd_ack
always_ff @(posedge i_clk) begin
    if (rd_req) begin
        o_cpu_rd_data <= i_rd_words[stream_idx];
    end
end

endmodule

//--- tcp_stream/tcp_stream_regs.sv
`timescale 1ns/1ps

module tcp_stream_regs (
    input  logic                                    i_clk,
    input  logic                                    i_rst,

    input  logic                                    i_wr_en,
    input  tcp_regs_pkg::reg_sel_e                  i_reg_sel,
    input  logic [tcp_regs_pkg::CPU_DATA_W-1:0]     i_wr_data,
    input  logic [tcp_regs_pkg::CPU_DATA_W-1:0]     i_wr_biten,
    output logic [tcp_regs_pkg::CPU_DATA_W-1:0]     o_rd_word,

    output logic                                    o_pending,
    input  logic                                    i_grant,

    output tcp_ip_pkg::ip_addr_t                    o_src_ip,
    output tcp_ip_pkg::ip_addr_t                    o_dst_ip,
    output tcp_ip_pkg::ttl_t                        o_ttl,
    output tcp_ip_pkg::proto_t                      o_proto,
    output tcp_ip_pkg::dscp_t                       o_dscp,
    output tcp_ip_pkg::ecn_t                        o_ecn,
    output tcp_ip_pkg::ip_len_t                     o_len
);

tcp_ip_pkg::ip_addr_t   src_ip_q;
tcp_ip_pkg::ip_addr_t   dst_ip_q;
tcp_ip_pkg::ttl_t       ttl_q;
tcp_ip_pkg::proto_t     proto_q;
tcp_ip_pkg::dscp_t      dscp_q;
tcp_ip_pkg::ecn_t       ecn_q;
tcp_ip_pkg::ip_len_t    len_q;
logic                   pending_q;

logic [tcp_regs_pkg::CPU_DATA_W-1:0] merged;
logic                                send_wr;

// current image of the selected register
always_comb begin
    o_rd_word = '0;
    unique case (i_reg_sel)
        tcp_regs_pkg::REG_CTRL: begin
            o_rd_word[tcp_regs_pkg::CTRL_LEN_LSB +: $bits(tcp_ip_pkg::ip_len_t)] = len_q;
            o_rd_word[tcp_regs_pkg::CTRL_SEND_BIT] = pending_q;
        end
        tcp_regs_pkg::REG_SRC_IP: o_rd_word = src_ip_q;
        tcp_regs_pkg::REG_DST_IP: o_rd_word = dst_ip_q;
        tcp_regs_pkg::REG_HDR: begin
            o_rd_word[tcp_regs_pkg::HDR_TTL_LSB +: $bits(tcp_ip_pkg::ttl_t)]     = ttl_q;
            o_rd_word[tcp_regs_pkg::HDR_PROTO_LSB +: $bits(tcp_ip_pkg::proto_t)] = proto_q;
            o_rd_word[tcp_regs_pkg::HDR_DSCP_LSB +: $bits(tcp_ip_pkg::dscp_t)]   = dscp_q;
            o_rd_word[tcp_regs_pkg::HDR_ECN_LSB +: $bits(tcp_ip_pkg::ecn_t)]     = ecn_q;
        end
        default: o_rd_word = '0;
    endcase
end

// bit-masked merge onto the current image
assign merged = (o_rd_word & ~i_wr_biten) | (i_wr_data & i_wr_biten);

assign send_wr = i_wr_en && (i_reg_sel == tcp_regs_pkg::REG_CTRL)
              && i_wr_biten[tcp_regs_pkg::CTRL_SEND_BIT]
              && i_wr_data[tcp_regs_pkg::CTRL_SEND_BIT];

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        src_ip_q  <= '0;
        dst_ip_q  <= '0;
        ttl_q     <= '0;
        proto_q   <= '0;
        dscp_q    <= '0;
        ecn_q     <= '0;
        len_q     <= '0;
        pending_q <= 1'b0;
    end else begin
        if (i_wr_en) begin
            unique case (i_reg_sel)
                tcp_regs_pkg::REG_CTRL:
                    len_q <= tcp_ip_pkg::ip_len_t'(merged >> tcp_regs_pkg::CTRL_LEN_LSB);
                tcp_regs_pkg::REG_SRC_IP: src_ip_q <= merged;
                tcp_regs_pkg::REG_DST_IP: dst_ip_q <= merged;
                tcp_regs_pkg::REG_HDR: begin
                    ttl_q   <= tcp_ip_pkg::ttl_t'(merged >> tcp_regs_pkg::HDR_TTL_LSB);
                    proto_q <= tcp_ip_pkg::proto_t'(merged >> tcp_regs_pkg::HDR_PROTO_LSB);
                    dscp_q  <= tcp_ip_pkg::dscp_t'(merged >> tcp_regs_pkg::HDR_DSCP_LSB);
                    ecn_q   <= tcp_ip_pkg::ecn_t'(merged >> tcp_regs_pkg::HDR_ECN_LSB);
                end
                default: ;
            endcase
        end
        // a send landing on the grant cycle is kept
        if (send_wr) begin
            pending_q <= 1'b1;
        end else if (i_grant) begin
            pending_q <= 1'b0;
        end
    end
end

assign o_pending = pending_q;
assign o_src_ip  = src_ip_q;
assign o_dst_ip  = dst_ip_q;
assign o_ttl     = ttl_q;
assign o_proto   = proto_q;
assign o_dscp    = dscp_q;
assign o_ecn     = ecn_q;
assign o_len     = len_q;

endmodule

//--- rtl/tcp_hdr_arb.sv
`timescale 1ns/1ps

module tcp_hdr_arb (
    input  logic                                            i_clk,
    input  logic                                            i_rst,

    input  logic [tcp_ip_pkg::NUM_TCP-1:0]                  i_req,
    input  tcp_ip_pkg::dscp_t    [tcp_ip_pkg::NUM_TCP-1:0]  i_dscp,
    input  tcp_ip_pkg::ecn_t     [tcp_ip_pkg::NUM_TCP-1:0]  i_ecn,
    input  tcp_ip_pkg::ip_len_t  [tcp_ip_pkg::NUM_TCP-1:0]  i_len,
    input  tcp_ip_pkg::ttl_t     [tcp_ip_pkg::NUM_TCP-1:0]  i_ttl,
    input  tcp_ip_pkg::proto_t   [tcp_ip_pkg::NUM_TCP-1:0]  i_proto,
    input  tcp_ip_pkg::ip_addr_t [tcp_ip_pkg::NUM_TCP-1:0]  i_src_ip,
    input  tcp_ip_pkg::ip_addr_t [tcp_ip_pkg::NUM_TCP-1:0]  i_dst_ip,
    output logic [tcp_ip_pkg::NUM_TCP-1:0]                  o_grant,

    output logic                                            o_hdr_valid,
    input  logic                                            i_hdr_ready,
    output tcp_ip_pkg::dscp_t                               o_dscp,
    output tcp_ip_pkg::ecn_t                                o_ecn,
    output tcp_ip_pkg::ip_len_t                             o_len,
    output tcp_ip_pkg::ttl_t                                o_ttl,
    output tcp_ip_pkg::proto_t                              o_proto,
    output tcp_ip_pkg::ip_addr_t                            o_src_ip,
    output tcp_ip_pkg::ip_addr_t                            o_dst_ip
);

logic [tcp_ip_pkg::STREAM_IDX_W-1:0] ptr;
logic [tcp_ip_pkg::STREAM_IDX_W-1:0] sel_idx;
logic                                found;
logic                                load;

// output slot free, or emptied on this edge
assign load = !o_hdr_valid || i_hdr_ready;

// first pending stream at or above ptr, wrapping
always_comb begin
    logic [tcp_ip_pkg::STREAM_IDX_W-1:0] idx;
    found   = 1'b0;
    sel_idx = '0;
    for (int k = 0; k < tcp_ip_pkg::NUM_TCP; k++) begin
        idx = ptr + tcp_ip_pkg::STREAM_IDX_W'(k);
        if (!found && i_req[idx]) begin
            found   = 1'b1;
            sel_idx = idx;
        end
    end
end

always_comb begin
    o_grant = '0;
    if (load && found) begin
        o_grant[sel_idx] = 1'b1;
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst) begin
        o_hdr_valid <= 1'b0;
        ptr         <= '0;
    end else if (load) begin
        o_hdr_valid <= found;
        if (found) begin
            ptr <= sel_idx + 1'b1;
        end
    end
end

// header fields sampled at grant
always_ff @(posedge i_clk) begin
    if (load && found) begin
        o_dscp   <= i_dscp[sel_idx];
        o_ecn    <= i_ecn[sel_idx];
        o_len    <= i_len[sel_idx];
        o_ttl    <= i_ttl[sel_idx];
        o_proto  <= i_proto[sel_idx];
        o_src_ip <= i_src_ip[sel_idx];
        o_dst_ip <= i_dst_ip[sel_idx];
    end
end

endmodule

//--- rtl/tcp.sv
`timescale 1ns/1ps

module tcp (
    input  logic                                    i_clk,
    input  logic                                    i_rst,

    input  logic                                    i_cpu_req,
    input  logic                                    i_cpu_req_is_wr,
    input  logic [tcp_regs_pkg::CPU_ADDR_W-1:0]     i_cpu_addr,
    input  logic [tcp_regs_pkg::CPU_DATA_W-1:0]     i_cpu_wr_data,
    input  logic [tcp_regs_pkg::CPU_DATA_W-1:0]     i_cpu_wr_biten,
    output logic                                    o_cpu_rd_ack,
    output logic [tcp_regs_pkg::CPU_DATA_W-1:0]     o_cpu_rd_data,
    output logic                                    o_cpu_wr_ack,

    // ip header output
    output logic                                    m_ip_hdr_valid,
    input  logic                                    m_ip_hdr_ready,
    output tcp_ip_pkg::dscp_t                       m_ip_dscp,
    output tcp_ip_pkg::ecn_t                        m_ip_ecn,
    output tcp_ip_pkg::ip_len_t                     m_ip_length,
    output tcp_ip_pkg::ttl_t                        m_ip_ttl,
    output tcp_ip_pkg::proto_t                      m_ip_protocol,
    output tcp_ip_pkg::ip_addr_t                    m_ip_source_ip,
    output tcp_ip_pkg::ip_addr_t                    m_ip_dest_ip
);

logic [tcp_ip_pkg::NUM_TCP-1:0]                              wr_en;
tcp_regs_pkg::reg_sel_e                                      reg_sel;
logic [tcp_ip_pkg::NUM_TCP-1:0][tcp_regs_pkg::CPU_DATA_W-1:0] rd_words;
logic [tcp_ip_pkg::NUM_TCP-1:0]                              pending;
logic [tcp_ip_pkg::NUM_TCP-1:0]                              grant;

tcp_ip_pkg::ip_addr_t [tcp_ip_pkg::NUM_TCP-1:0] src_ip;
tcp_ip_pkg::ip_addr_t [tcp_ip_pkg::NUM_TCP-1:0] dst_ip;
tcp_ip_pkg::ttl_t     [tcp_ip_pkg::NUM_TCP-1:0] ttl;
tcp_ip_pkg::proto_t   [tcp_ip_pkg::NUM_TCP-1:0] proto;
tcp_ip_pkg::dscp_t    [tcp_ip_pkg::NUM_TCP-1:0] dscp;
tcp_ip_pkg::ecn_t     [tcp_ip_pkg::NUM_TCP-1:0] ecn;
tcp_ip_pkg::ip_len_t  [tcp_ip_pkg::NUM_TCP-1:0] len;

tcp_reg_decode u_tcp_reg_decode (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_cpu_req          (i_cpu_req),
    .i_cpu_req_is_wr    (i_cpu_req_is_wr),
    .i_cpu_addr         (i_cpu_addr),
    .o_wr_en            (wr_en),
    .o_reg_sel          (reg_sel),
    .i_rd_words         (rd_words),
    .o_cpu_rd_ack       (o_cpu_rd_ack),
    .o_cpu_wr_ack       (o_cpu_wr_ack),
    .o_cpu_rd_data      (o_cpu_rd_data)
);

// one register set per stream
for (genvar i = 0; i < tcp_ip_pkg::NUM_TCP; i++) begin : g_stream
    tcp_stream_regs u_tcp_stream_regs (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_wr_en        (wr_en[i]),
        .i_reg_sel      (reg_sel),
        .i_wr_data      (i_cpu_wr_data),
        .i_wr_biten     (i_cpu_wr_biten),
        .o_rd_word      (rd_words[i]),
        .o_pending      (pending[i]),
        .i_grant        (grant[i]),
        .o_src_ip       (src_ip[i]),
        .o_dst_ip       (dst_ip[i]),
        .o_ttl          (ttl[i]),
        .o_proto        (proto[i]),
        .o_dscp         (dscp[i]),
        .o_ecn          (ecn[i]),
        .o_len          (len[i])
    );
end

tcp_hdr_arb u_tcp_hdr_arb (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_req              (pending),
    .i_dscp             (dscp),
    .i_ecn              (ecn),
    .i_len              (len),
    .i_ttl              (ttl),
    .i_proto            (proto),
    .i_src_ip           (src_ip),
    .i_dst_ip           (dst_ip),
    .o_grant            (grant),
    .o_hdr_valid        (m_ip_hdr_valid),
    .i_hdr_ready        (m_ip_hdr_ready),
    .o_dscp             (m_ip_dscp),
    .o_ecn              (m_ip_ecn),
    .o_len              (m_ip_length),
    .o_ttl              (m_ip_ttl),
    .o_proto            (m_ip_protocol),
    .o_src_ip           (m_ip_source_ip),
    .o_dst_ip           (m_ip_dest_ip)
);

endmodule

//--- tb/tcp_chk.sv
`timescale 1ns/1ps

module tcp_chk (
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_cpu_req,
    input  logic         i_cpu_req_is_wr,
    input  logic         i_cpu_rd_ack,
    input  logic         i_cpu_wr_ack,
    input  logic         i_hdr_valid,
    input  logic         i_hdr_ready,
    input  logic [103:0] i_hdr_fields
);

wr_ack_after_req: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_cpu_req && i_cpu_req_is_wr) |=> i_cpu_wr_ack)
    else $error("write request not acknowledged one cycle later");

rd_ack_after_req: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_cpu_req && !i_cpu_req_is_wr) |=> i_cpu_rd_ack)
    else $error("read request not acknowledged one cycle later");

// acks only ever answer a request
ack_has_req: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_cpu_rd_ack || i_cpu_wr_ack) |-> $past(i_cpu_req))
    else $error("acknowledge without a request");

// stalled header holds
hdr_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_hdr_valid && !i_hdr_ready) |=> (i_hdr_valid && $stable(i_hdr_fields)))
    else $error("header changed while stalled");

endmodule

//--- tb/tcp_tb.sv
`timescale 1ns/1ps

module tcp_tb;

typedef enum logic [2:0] {
    OP_WR,
    OP_RD,
    OP_READY,
    OP_DRAIN,
    OP_END
} op_e;

typedef struct packed {
    op_e         op;
    logic [4:0]  addr;
    logic [31:0] data;
    logic [31:0] biten;
    logic [31:0] exp;
} row_t;

// ttl, protocol, dscp and ecn fill the low 24 bits
localparam logic [31:0] HDR_MASK = 32'h00ff_ffff;

logic        i_clk = 1'b0;
logic        i_rst;
logic        i_cpu_req;
logic        i_cpu_req_is_wr;
logic [4:0]  i_cpu_addr;
logic [31:0] i_cpu_wr_data;
logic [31:0] i_cpu_wr_biten;
logic        o_cpu_rd_ack;
logic [31:0] o_cpu_rd_data;
logic        o_cpu_wr_ack;
logic        m_ip_hdr_valid;
logic        m_ip_hdr_ready = 1'b0;
logic [5:0]  m_ip_dscp;
logic [1:0]  m_ip_ecn;
logic [15:0] m_ip_length;
logic [7:0]  m_ip_ttl;
logic [7:0]  m_ip_protocol;
logic [31:0] m_ip_source_ip;
logic [31:0] m_ip_dest_ip;

row_t       rows[$];
logic       table_ready = 1'b0;
logic [1:0] ready_mode = 2'd0;
int         n_errors = 0;
int         n_checks = 0;
int         n_tests = 0;
int         test_errors = 0;

// reference model of register images, pending set, pointer and output slot
logic [31:0] img_src [8];
logic [31:0] img_dst [8];
logic [31:0] img_hdr [8];
logic [15:0] img_len [8];
logic [7:0]  pend = '0;
logic [2:0]  rr_ptr = '0;
logic        slot_full = 1'b0;
logic [2:0]  slot_idx;
logic [31:0] slot_src;
logic [31:0] slot_dst;
logic [31:0] slot_hdr;
logic [15:0] slot_len;

tcp tcp_inst (.*);

bind tcp tcp_chk u_tcp_chk (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_cpu_req       (i_cpu_req),
    .i_cpu_req_is_wr (i_cpu_req_is_wr),
    .i_cpu_rd_ack    (o_cpu_rd_ack),
    .i_cpu_wr_ack    (o_cpu_wr_ack),
    .i_hdr_valid     (m_ip_hdr_valid),
    .i_hdr_ready     (m_ip_hdr_ready),
    .i_hdr_fields    ({m_ip_dscp, m_ip_ecn, m_ip_length, m_ip_ttl, m_ip_protocol,
                       m_ip_source_ip, m_ip_dest_ip})
);

always #50 i_clk = ~i_clk;

always @(negedge i_clk) begin
    if (ready_mode == 2'd2) begin
        m_ip_hdr_ready <= 1'($urandom % 2);
    end else begin
        m_ip_hdr_ready <= ready_mode[0];
    end
end

function automatic logic [4:0] addr_of(input int s, input tcp_regs_pkg::reg_sel_e r);
    return {3'(s), r};
endfunction

function automatic logic [31:0] src_ip_of(input int s);
    return 32'hc0a8_0100 + 32'(s);
endfunction

function automatic logic [31:0] dst_ip_of(input int s);
    return 32'h0a00_002a + 32'(s) * 32'h100;
endfunction

// nonzero upper byte for most streams
function automatic logic [31:0] hdr_word_of(input int s);
    return 32'hff00_0640 + 32'(s) * 32'h0101_0001;
endfunction

function automatic logic [31:0] send_word_of(input int s);
    return {16'd64 + 16'(s * 100), 16'h0001};
endfunction

task automatic add_row(input op_e op, input logic [4:0] addr, input logic [31:0] data,
                       input logic [31:0] biten, input logic [31:0] exp);
    rows.push_back('{op: op, addr: addr, data: data, biten: biten, exp: exp});
endtask

task automatic add_send(input int s);
    add_row(OP_WR, addr_of(s, tcp_regs_pkg::REG_CTRL), send_word_of(s), '1, '0);
endtask

task automatic build_table();
    for (int a = 0; a < 32; a++) begin
        add_row(OP_RD, 5'(a), '0, '0, '0);
    end
    add_row(OP_END, '0, 1, '0, '0);
    for (int s = 0; s < 8; s++) begin
        add_row(OP_WR, addr_of(s, tcp_regs_pkg::REG_SRC_IP), src_ip_of(s), '1, '0);
        add_row(OP_RD, addr_of(s, tcp_regs_pkg::REG_SRC_IP), '0, '0, src_ip_of(s));
        add_row(OP_WR, addr_of(s, tcp_regs_pkg::REG_DST_IP), dst_ip_of(s), '1, '0);
        add_row(OP_RD, addr_of(s, tcp_regs_pkg::REG_DST_IP), '0, '0, dst_ip_of(s));
        add_row(OP_WR, addr_of(s, tcp_regs_pkg::REG_HDR), hdr_word_of(s), '1, '0);
        add_row(OP_RD, addr_of(s, tcp_regs_pkg::REG_HDR), '0, '0, hdr_word_of(s) & HDR_MASK);
    end
    add_row(OP_END, '0, 2, '0, '0);
    add_row(OP_WR, addr_of(3, tcp_regs_pkg::REG_SRC_IP), 32'h1122_3344, 32'hff00_00ff, '0);
    add_row(OP_RD, addr_of(3, tcp_regs_pkg::REG_SRC_IP), '0, '0,
            (src_ip_of(3) & 32'h00ff_ff00) | 32'h1100_0044);
    add_row(OP_END, '0, 3, '0, '0);
    add_row(OP_READY, '0, 1, '0, '0);
    add_send(4);
    add_row(OP_RD, addr_of(4, tcp_regs_pkg::REG_CTRL), '0, '0, send_word_of(4));
    add_row(OP_DRAIN, '0, '0, '0, '0);
    add_row(OP_RD, addr_of(4, tcp_regs_pkg::REG_CTRL), '0, '0, send_word_of(4) & ~32'h1);
    add_row(OP_END, '0, 4, '0, '0);
    add_row(OP_READY, '0, 0, '0, '0);
    add_send(5);
    add_send(2);
    add_send(7);
    add_send(2);
    add_row(OP_READY, '0, 1, '0, '0);
    add_row(OP_DRAIN, '0, '0, '0, '0);
    add_row(OP_END, '0, 5, '0, '0);
    add_row(OP_READY, '0, 0, '0, '0);
    for (int s = 0; s < 8; s++) begin
        add_send(s);
    end
    add_row(OP_READY, '0, 2, '0, '0);
    add_row(OP_DRAIN, '0, '0, '0, '0);
    add_row(OP_END, '0, 6, '0, '0);
endtask

// load the slot with the first pending stream at or above the pointer
task automatic grant_next();
    logic [2:0] idx;
    for (int k = 0; k < 8; k++) begin
        idx = rr_ptr + 3'(k);
        if (!slot_full && pend[idx]) begin
            slot_full = 1'b1;
            slot_idx  = idx;
            pend[idx] = 1'b0;
            rr_ptr    = idx + 3'd1;
            slot_src  = img_src[idx];
            slot_dst  = img_dst[idx];
            slot_hdr  = img_hdr[idx];
            slot_len  = img_len[idx];
        end
    end
endtask

task automatic model_write(input row_t r);
    int          s;
    logic [31:0] m;
    s = int'(r.addr[4:2]);
    m = r.biten;
    case (r.addr[1:0])
        2'd0: begin
            img_len[s] = (img_len[s] & ~m[31:16]) | (r.data[31:16] & m[31:16]);
            if (m[0] && r.data[0]) begin
                pend[s] = 1'b1;
                grant_next();
            end
        end
        2'd1: img_src[s] = (img_src[s] & ~m) | (r.data & m);
        2'd2: img_dst[s] = (img_dst[s] & ~m) | (r.data & m);
        default: img_hdr[s] = ((img_hdr[s] & ~m) | (r.data & m)) & HDR_MASK;
    endcase
endtask

task automatic access(input row_t r);
    i_cpu_req       = 1'b1;
    i_cpu_req_is_wr = (r.op == OP_WR);
    i_cpu_addr      = r.addr;
    i_cpu_wr_data   = r.data;
    i_cpu_wr_biten  = r.biten;
    if (r.op == OP_WR) begin
        model_write(r);
    end
    @(negedge i_clk);
    i_cpu_req = 1'b0;
    n_checks++;
    if (r.op == OP_WR && !(o_cpu_wr_ack && !o_cpu_rd_ack)) begin
        n_errors++;
        $display("write to address %h was not acknowledged one cycle later", r.addr);
    end
    if (r.op == OP_RD) begin
        if (!(o_cpu_rd_ack && !o_cpu_wr_ack)) begin
            n_errors++;
            $display("read of address %h was not acknowledged one cycle later", r.addr);
        end else if (o_cpu_rd_data != r.exp) begin
            n_errors++;
            $display("error %0t: read of address %h returned %h, expected %h",
                     $time, r.addr, o_cpu_rd_data, r.exp);
        end
    end
endtask

task automatic check_header();
    logic [31:0] obs_hdr;
    obs_hdr = '0;
    obs_hdr[tcp_regs_pkg::HDR_TTL_LSB +: 8]   = m_ip_ttl;
    obs_hdr[tcp_regs_pkg::HDR_PROTO_LSB +: 8] = m_ip_protocol;
    obs_hdr[tcp_regs_pkg::HDR_DSCP_LSB +: 6]  = m_ip_dscp;
    obs_hdr[tcp_regs_pkg::HDR_ECN_LSB +: 2]   = m_ip_ecn;
    n_checks++;
    if (obs_hdr != slot_hdr || m_ip_length != slot_len
            || m_ip_source_ip != slot_src || m_ip_dest_ip != slot_dst) begin
        n_errors++;
        $display("error %0t: header does not match stream %0d (len %h src %h dst %h)",
                 $time, slot_idx, m_ip_length, m_ip_source_ip, m_ip_dest_ip);
    end
endtask

// header transfers seen at the clock edge
always @(posedge i_clk) begin
    if (!i_rst && m_ip_hdr_valid) begin
        if (!slot_full) begin
            n_errors++;
            $display("a header was presented while no send was outstanding");
        end else if (m_ip_hdr_ready) begin
            check_header();
            slot_full = 1'b0;
            grant_next();
        end
    end
end

initial begin
    i_rst           = 1'b1;
    i_cpu_req       = 1'b0;
    i_cpu_req_is_wr = 1'b0;
    i_cpu_addr      = '0;
    i_cpu_wr_data   = '0;
    i_cpu_wr_biten  = '0;
    void'($urandom(99847));
    for (int s = 0; s < 8; s++) begin
        img_src[s] = '0;
        img_dst[s] = '0;
        img_hdr[s] = '0;
        img_len[s] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (4) @(negedge i_clk);
    i_rst = 1'b0;
    foreach (rows[i]) begin
        case (rows[i].op)
            OP_WR, OP_RD: access(rows[i]);
            OP_READY: begin
                ready_mode <= rows[i].data[1:0];
                repeat (2) @(negedge i_clk);
            end
            OP_DRAIN: begin
                while (slot_full || pend != '0) begin
                    @(negedge i_clk);
                end
                repeat (3) @(negedge i_clk);
            end
            default: begin
                n_tests++;
                if (n_errors == test_errors) begin
                    $display("test %0d passed", rows[i].data);
                end else begin
                    $display("test %0d failed with %0d errors", rows[i].data,
                             n_errors - test_errors);
                end
                test_errors = n_errors;
            end
        endcase
    end
    repeat (4) @(negedge i_clk);
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
        $display("RESULT: PASS");
    end else begin
        $display("RESULT: FAIL");
    end
    $finish;
end

// watchdog
initial begin
    wait (table_ready);
    repeat (rows.size() * 40) @(posedge i_clk);
    $display("timeout, the tests did not finish within %0d cycles", rows.size() * 40);
    $display("RESULT: FAIL");
    $finish;
end

endmodule

//--- filelist.f
common/tcp_ip_pkg.sv
common/tcp_regs_pkg.sv
rtl/tcp_reg_decode.sv
tcp_stream/tcp_stream_regs.sv
rtl/tcp_hdr_arb.sv
rtl/tcp.sv
tb/tcp_chk.sv
tb/tcp_tb.sv

//--- run.sh
#!/bin/sh
# build and run the tcp testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tcp_tb -o tcp_tb_sim \
    && ./obj_dir/tcp_tb_sim | tee /dev/stderr | grep "RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
